//--- div_array_top.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_array_top
    import div_req_pkg::*;
    import div_resp_pkg::*;
(
    input  logic      I_clk,
    input  logic      I_reset,
    input  logic      req_valid,
    input  div_req_t  req,
    output logic      full,
    output logic      resp_valid,
    output div_resp_t resp
);
    logic [`DIV_LANES-1:0] lane_start;
    logic [`DIV_LANES-1:0] lane_busy;
    logic [`DIV_LANES-1:0] lane_done;
    div_req_t              lane_req;
    div_resp_t             lane_resp [`DIV_LANES];

    div_dispatch u_dispatch (
        .I_clk      (I_clk),
        .I_reset    (I_reset),
        .req_valid  (req_valid),
        .req        (req),
        .lane_busy  (lane_busy),
        .lane_start (lane_start),
        .lane_req   (lane_req),
        .full       (full)
    );

    // identical lanes sharing one registered request bus
    for (genvar i = 0; i < `DIV_LANES; i++) begin : g_lane
        div_lane u_lane (
            .I_clk   (I_clk),
            .I_reset (I_reset),
            .start   (lane_start[i]),
            .req     (lane_req),
            .busy    (lane_busy[i]),
            .done    (lane_done[i]),
            .resp    (lane_resp[i])
        );
    end

    div_collect u_collect (
        .I_clk      (I_clk),
        .I_reset    (I_reset),
        .lane_done  (lane_done),
        .lane_resp  (lane_resp),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

//--- div_collect.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_collect
    import div_resp_pkg::*;
(
    input  logic                  I_clk,
    input  logic                  I_reset,
    input  logic [`DIV_LANES-1:0] lane_done,
    input  div_resp_t             lane_resp [`DIV_LANES],
    output logic                  resp_valid,
    output div_resp_t             resp
);
    localparam int N = `DIV_LANES;

    div_resp_t sel_resp;

    // and-or mux, lane_done is one-hot at most
    always_comb begin
        sel_resp = '0;
        for (int i = 0; i < N; i++) begin
            if (lane_done[i]) begin
                sel_resp = sel_resp | lane_resp[i];
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= |lane_done;
        end
    end

    always_ff @(posedge I_clk) begin
        if (|lane_done) begin
            resp <= sel_resp;
        end
    end

    // equal lane latency and one request per cycle keep completions apart
    a_done_onehot: assert property (@(posedge I_clk) disable iff (I_reset)
        $onehot0(lane_done))
        else $error("div_collect saw two lanes finish together");

endmodule

//--- div_dispatch.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_dispatch
    import div_req_pkg::*;
(
    input  logic                  I_clk,
    input  logic                  I_reset,
    input  logic                  req_valid,
    input  div_req_t              req,
    input  logic [`DIV_LANES-1:0] lane_busy,
    output logic [`DIV_LANES-1:0] lane_start,
    output div_req_t              lane_req,
    output logic                  full
);
    localparam int N = `DIV_LANES;

    logic [N-1:0] lane_free;
    logic [N-1:0] pick;

    // a lane started last cycle has not raised busy yet
    assign lane_free = ~(lane_busy | lane_start);

    // isolate the lowest free lane
    assign pick = lane_free & (~lane_free + 1'b1);

    assign full = ~|lane_free;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            lane_start <= '0;
        end else begin
            lane_start <= req_valid ? pick : '0;  // dropped when nothing is free
        end
    end

    // shared by all lanes, only the started one samples it
    always_ff @(posedge I_clk) begin
        if (req_valid) begin
            lane_req <= req;
        end
    end

    a_start_onehot: assert property (@(posedge I_clk) disable iff (I_reset)
        $onehot0(lane_start))
        else $error("div_dispatch started more than one lane");

    // requester has to watch full before strobing
    a_no_req_when_full: assert property (@(posedge I_clk) disable iff (I_reset)
        req_valid |-> !full)
        else $error("div_dispatch request dropped while full");

endmodule

//--- div_lane.sv
`timescale 1ns/100ps
`include "div_params.svh"

module div_lane
    import div_req_pkg::*;
    import div_resp_pkg::*;
(
    input  logic      I_clk,
    input  logic      I_reset,
    input  logic      start,
    input  div_req_t  req,
    output logic      busy,
    output logic      done,
    output div_resp_t resp
);
    localparam int W = `DIV_WIDTH;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,
        ST_DONE,
        ST_DELAY
    } state_t;

    state_t                   state;
    logic [W-1:0]             quotient;
    logic [W-1:0]             quot_mask;
    logic [W-1:0]             dividend;
    logic [2*W-2:0]           divisor;     // slides right one bit per cycle
    logic                     divisor_nz;
    logic                     finished;
    logic                     op_divide;
    logic                     op_signed;
    logic                     dvd_sign;
    logic                     dvs_sign;
    logic [`DIV_TAG_BITS-1:0] tag_q;

    logic                     neg_dividend;
    logic                     neg_divisor;
    logic                     neg_result;
    logic [W-1:0]             raw_result;

    // operands are taken as magnitudes, sign restored at the end
    assign neg_dividend = req.signed_op && req.dividend[W-1];
    assign neg_divisor  = req.signed_op && req.divisor[W-1];

    // a zero divisor keeps the quotient at all ones
    assign neg_result = (op_divide && op_signed && (dvd_sign != dvs_sign) && divisor_nz)
                      || (!op_divide && op_signed && dvd_sign);

    assign raw_result = op_divide ? quotient : dividend;  // remainder is what is left
    assign busy       = (state != ST_IDLE);

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    quotient   <= '0;
                    quot_mask  <= {1'b1, {(W-1){1'b0}}};
                    finished   <= 1'b0;
                    divisor_nz <= 1'b0;
                    if (start) begin
                        dividend  <= neg_dividend ? -req.dividend : req.dividend;
                        divisor   <= {(neg_divisor ? -req.divisor : req.divisor),
                                      {(W-1){1'b0}}};
                        op_divide <= req.divide;
                        op_signed <= req.signed_op;
                        dvd_sign  <= req.dividend[W-1];
                        dvs_sign  <= req.divisor[W-1];
                        tag_q     <= req.tag;
                        state     <= ST_ITER;
                    end
                end
                ST_ITER: begin
                    if (finished) begin
                        resp.result <= neg_result ? -raw_result : raw_result;
                        resp.tag    <= tag_q;
                        done        <= 1'b1;
                        state       <= ST_DONE;
                    end
                    // every divisor bit passes position W-1 once
                    divisor_nz <= divisor_nz | divisor[W-1];
                    if (divisor <= {{(W-1){1'b0}}, dividend}) begin
                        dividend <= dividend - divisor[W-1:0];  // upper bits are zero here
                        quotient <= quotient | quot_mask;
                    end
                    finished  <= quot_mask[0];
                    divisor   <= divisor >> 1;
                    quot_mask <= quot_mask >> 1;
                end
                ST_DONE: begin
                    done  <= 1'b0;
                    state <= ST_DELAY;
                end
                ST_DELAY: begin
                    state <= ST_IDLE;  // busy drops one cycle after the done pulse
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // the dispatcher must never start a lane that still holds work
    a_start_idle: assert property (@(posedge I_clk) disable iff (I_reset)
        start |-> !busy)
        else $error("div_lane started while busy");

endmodule

//--- div_params.svh
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand and result width
`define DIV_WIDTH 32

// divider lanes, works from 2 up to 8
`define DIV_LANES 4

// request tag width, results may return out of order
`define DIV_TAG_BITS 4

`endif

//--- div_req_pkg.sv
package div_req_pkg;

`include "div_params.svh"

    // one division request as it enters the unit
    typedef struct packed {
        logic [`DIV_WIDTH-1:0]    dividend;
        logic [`DIV_WIDTH-1:0]    divisor;
        logic                     divide;     // 1 quotient, 0 remainder
        logic                     signed_op;  // DIV/REM vs DIVU/REMU
        logic [`DIV_TAG_BITS-1:0] tag;
    } div_req_t;

endpackage

//--- div_resp_pkg.sv
package div_resp_pkg;

`include "div_params.svh"

    // one completed division
    typedef struct packed {
        logic [`DIV_WIDTH-1:0]    result;
        logic [`DIV_TAG_BITS-1:0] tag;   // copied from the request
    } div_resp_t;

endpackage

//--- div_vectors.txt
# columns: dividend divisor divide signed_op expected, all hex
# divide 1 gives the quotient, 0 the remainder
@unsigned
00000064 00000007 1 0 0000000e
00000064 00000007 0 0 00000002
ffffffff 00000010 1 0 0fffffff
ffffffff 00000010 0 0 0000000f
80000000 00000003 1 0 2aaaaaaa
80000000 00000003 0 0 00000002
00000005 0000000a 1 0 00000000
fffffffe ffffffff 0 0 fffffffe
@signed
00000007 00000002 1 1 00000003
00000007 00000002 0 1 00000001
fffffff9 00000002 1 1 fffffffd
fffffff9 00000002 0 1 ffffffff
00000007 fffffffe 1 1 fffffffd
00000007 fffffffe 0 1 00000001
fffffff9 fffffffe 1 1 00000003
fffffff9 fffffffe 0 1 ffffffff
@corner
00001234 00000000 1 0 ffffffff
00001234 00000000 0 0 00001234
fffffff9 00000000 1 1 ffffffff
fffffff9 00000000 0 1 fffffff9
80000000 ffffffff 1 1 80000000
80000000 ffffffff 0 1 00000000
@burst
000003e8 0000000a 1 0 00000064
000003e8 00000007 0 0 00000006
ffffff38 0000000a 1 1 ffffffec
ffffff38 00000007 0 1 fffffffc
deadbeef 00010000 0 0 0000beef
deadbeef 00010000 1 0 0000dead
00000100 00000000 1 1 ffffffff
7fffffff 7fffffff 1 1 00000001
80000000 ffffffff 1 1 80000000
00000063 00000009 1 0 0000000b

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_div_array -o tb_div_array_sim \
    && ./obj_dir/tb_div_array_sim | tee /dev/stderr | grep -qx "Test passed" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }

//--- src.f
+incdir+.
div_req_pkg.sv
div_resp_pkg.sv
div_lane.sv
div_dispatch.sv
div_collect.sv
div_array_top.sv
tb_clock_gen.sv
tb_div_array.sv

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic I_clk,
    output logic I_reset
);
    initial begin
        I_clk = 1'b0;
        forever #50 I_clk = ~I_clk;  // 100 ns period
    end

    // reset held over the first three rising edges
    initial begin
        I_reset = 1'b1;
        repeat (3) @(posedge I_clk);
        I_reset <= 1'b0;
    end

endmodule

//--- tb_div_array.sv
`timescale 1ns/100ps
`include "div_params.svh"

module tb_div_array
    import div_req_pkg::*;
    import div_resp_pkg::*;
();
    localparam int TIMEOUT = 200;  // cycles without progress
    localparam int MAX_VEC = 64;
    localparam int NTAGS   = 1 << `DIV_TAG_BITS;

    logic      I_clk;
    logic      I_reset;
    logic      req_valid;
    div_req_t  req;
    logic      full;
    logic      resp_valid;
    div_resp_t resp;

    logic [`DIV_WIDTH-1:0]    vec_dvd [MAX_VEC];
    logic [`DIV_WIDTH-1:0]    vec_dvs [MAX_VEC];
    logic                     vec_div [MAX_VEC];
    logic                     vec_sgn [MAX_VEC];
    logic [`DIV_WIDTH-1:0]    vec_exp [MAX_VEC];
    int                       vec_grp [MAX_VEC];
    string                    grp_name [8];
    int                       num_vec;
    int                       num_grp;
    bit                       load_ok;
    logic [`DIV_WIDTH-1:0]    exp_by_tag [NTAGS];  // expected result per tag in flight
    bit                       pending [NTAGS];
    logic [`DIV_TAG_BITS-1:0] next_tag;
    int                       outstanding;
    int                       errors;
    int                       checks;
    int                       tests;
    bit                       timed_out;

    tb_clock_gen clkgen (.I_clk(I_clk), .I_reset(I_reset));

    div_array_top dut (
        .I_clk      (I_clk),
        .I_reset    (I_reset),
        .req_valid  (req_valid),
        .req        (req),
        .full       (full),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // lines starting with @ open a new group of vectors
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] a, b, d, s, e;
        fd = $fopen("div_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open div_vectors.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
            if (line[0] == "@" && num_grp < 8) begin
                n = $sscanf(line, "@%s", name);
                grp_name[num_grp] = name;
                num_grp++;
            end else if (num_grp > 0 && num_vec < MAX_VEC) begin
                n = $sscanf(line, "%h %h %h %h %h", a, b, d, s, e);
                if (n == 5) begin
                    vec_dvd[num_vec] = a;
                    vec_dvs[num_vec] = b;
                    vec_div[num_vec] = d[0];
                    vec_sgn[num_vec] = s[0];
                    vec_exp[num_vec] = e;
                    vec_grp[num_vec] = num_grp - 1;
                    num_vec++;
                end
            end
        end
        $fclose(fd);
        load_ok = (num_vec > 0);
        if (!load_ok) begin
            $display("no vectors found in div_vectors.txt");
            errors++;
        end
    endtask

    task automatic idle_check();
        int cnt;
        int err0;
        err0 = errors;
        cnt  = 0;
        while (I_reset && cnt < TIMEOUT) begin
            @(negedge I_clk);
            cnt++;
        end
        if (I_reset) begin
            $display("timeout: reset was never released");
            timed_out = 1;
            errors++;
        end else begin
            repeat (8) begin
                @(negedge I_clk);
                check("full", 32'(full), 32'h0);
                check("resp_valid", 32'(resp_valid), 32'h0);
            end
        end
        tests++;
        $display("test idle: %0d errors", errors - err0);
    endtask

    task automatic take_result(input bit single, input logic [`DIV_TAG_BITS-1:0] want_tag);
        // one request in flight, so the tag must be the one just sent
        if (single) check("resp.tag", 32'(resp.tag), 32'(want_tag));
        if (!pending[resp.tag]) begin
            errors++;
            $display("result arrived with tag %0d that is not in flight", resp.tag);
        end else begin
            check("resp.result", resp.result, exp_by_tag[resp.tag]);
            pending[resp.tag] = 1'b0;
            outstanding--;
        end
    endtask

    // single groups keep one request in flight, the burst group fills every lane
    task automatic run_group(input int grp);
        int                       idx[$];
        int                       sent;
        int                       idle;
        int                       err0;
        int                       v;
        bit                       burst;
        bit                       saw_full;
        logic [`DIV_TAG_BITS-1:0] last_tag;
        for (int i = 0; i < num_vec; i++) begin
            if (vec_grp[i] == grp) idx.push_back(i);
        end
        burst    = (grp_name[grp] == "burst");
        err0     = errors;
        sent     = 0;
        idle     = 0;
        saw_full = 0;
        last_tag = '0;
        while ((sent < idx.size() || outstanding > 0) && !timed_out) begin
            @(negedge I_clk);
            req_valid = 1'b0;
            if (resp_valid) begin
                take_result(!burst, last_tag);
                idle = 0;
            end
            if (full) saw_full = 1;
            if (sent < idx.size() && !full && (burst || outstanding == 0)) begin
                v            = idx[sent];
                req.dividend = vec_dvd[v];
                req.divisor  = vec_dvs[v];
                req.divide   = vec_div[v];
                req.signed_op = vec_sgn[v];
                req.tag      = next_tag;
                exp_by_tag[next_tag] = vec_exp[v];
                pending[next_tag]    = 1'b1;
                last_tag     = next_tag;
                next_tag     = next_tag + 1'b1;  // wraps modulo 16
                outstanding++;
                req_valid    = 1'b1;
                sent++;
                idle = 0;
            end else if (++idle > TIMEOUT) begin
                $display("timeout: test %s got no result for %0d cycles", grp_name[grp], TIMEOUT);
                timed_out = 1;
                errors++;
            end
        end
        if (burst && !saw_full) begin
            $display("full never rose while the burst kept every lane busy");
            errors++;
        end
        tests++;
        $display("test %s: %0d vectors, %0d errors", grp_name[grp], idx.size(), errors - err0);
    endtask

    initial begin
        req_valid   = 1'b0;
        req         = '0;
        next_tag    = '0;
        outstanding = 0;
        num_vec     = 0;
        num_grp     = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        timed_out   = 0;
        load_ok     = 0;
        for (int t = 0; t < NTAGS; t++) pending[t] = 1'b0;
        load_vectors();
        idle_check();
        for (int g = 0; g < num_grp && load_ok && !timed_out; g++) run_group(g);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && load_ok && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
